//--- adder_sub.sv
// ripple-carry adder / subtractor with optional inversion of operand b
`timescale 1ns/1ps

module adder_sub import alu_pkg::*; (
  input  logic [DATA_WIDTH-1:0] op_a_i,
  input  logic [DATA_WIDTH-1:0] op_b_i,
  input  logic                  inv_b_i,  // high for subtract
  output logic [DATA_WIDTH-1:0] res_o,
  output logic                  carry_o
);

  logic [DATA_WIDTH-1:0] b_eff;    // operand b after optional inversion
  logic [DATA_WIDTH:0]   carry;    // carry chain, bit 0 is carry in
  logic [DATA_WIDTH-1:0] prop;     // propagate per bit

  assign b_eff    = op_b_i ^ {DATA_WIDTH{inv_b_i}};
  assign carry[0] = inv_b_i;       // +1 completes two's complement

  ////////////////////////////////////////////////////////////
  // full adder chain
  ////////////////////////////////////////////////////////////
  genvar i;
  generate
    for (i = 0; i < DATA_WIDTH; i++) begin : g_fa
      assign prop[i]    = op_a_i[i] ^ b_eff[i];
      assign res_o[i]   = prop[i] ^ carry[i];
      assign carry[i+1] = (op_a_i[i] & b_eff[i]) | (carry[i] & prop[i]);
    end
  endgenerate

  assign carry_o = carry[DATA_WIDTH];  // on sub, 1 means no borrow

endmodule : adder_sub

//--- alu.sv
// registered alu, result plus destination and writeback flag one cycle later
`timescale 1ns/1ps

module alu import alu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [ALU_OP_WIDTH-1:0]   sel_i,        // operation select
  input  logic [DATA_WIDTH-1:0]     op_a_i,
  input  logic [DATA_WIDTH-1:0]     op_b_i,
  output logic [DATA_WIDTH-1:0]     res_ro,
  output logic                      carry_ro,     // add / sub carry only
  input  logic [REG_ADDR_WIDTH-1:0] dest_addr_i,
  output logic [REG_ADDR_WIDTH-1:0] dest_addr_ro,
  input  logic                      wb_i,
  output logic                      wb_ro
);

  logic [DATA_WIDTH-1:0] adder_res;
  logic                  adder_carry;
  logic [DATA_WIDTH-1:0] shift_res;
  logic [DATA_WIDTH-1:0] slt_res;
  logic [DATA_WIDTH-1:0] sltu_res;
  logic [DATA_WIDTH-1:0] res_mux;
  logic                  is_addsub;

  ////////////////////////////////////////////////////////////
  // arithmetic
  ////////////////////////////////////////////////////////////
  adder_sub u_adder_sub (
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .inv_b_i (sel_i[3]),      // sub
    .res_o   (adder_res),
    .carry_o (adder_carry)
  );

  barrel_shifter u_shifter (
    .data_i  (op_a_i),
    .shamt_i (op_b_i[SHAMT_WIDTH-1:0]),
    .right_i (sel_i[2]),      // srl / sra have funct3 = 101
    .arith_i (sel_i[3]),
    .data_o  (shift_res)
  );

  // compares give 0 or 1
  assign slt_res  = {{(DATA_WIDTH-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
  assign sltu_res = {{(DATA_WIDTH-1){1'b0}}, op_a_i < op_b_i};

  assign is_addsub = (sel_i == ALU_OP_ADD) || (sel_i == ALU_OP_SUB);

  ////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (sel_i)
      ALU_OP_ADD,
      ALU_OP_SUB:  res_mux = adder_res;
      ALU_OP_SLL,
      ALU_OP_SRL,
      ALU_OP_SRA:  res_mux = shift_res;
      ALU_OP_SLT:  res_mux = slt_res;
      ALU_OP_SLTU: res_mux = sltu_res;
      ALU_OP_XOR:  res_mux = op_a_i ^ op_b_i;
      ALU_OP_OR:   res_mux = op_a_i | op_b_i;
      ALU_OP_AND:  res_mux = op_a_i & op_b_i;
      default:     res_mux = '0;             // unused codes
    endcase
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    res_ro       <= res_mux;
    dest_addr_ro <= dest_addr_i;
  end

  // control registers
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_ro    <= 1'b0;
      carry_ro <= 1'b0;
    end else begin
      wb_ro    <= wb_i;
      carry_ro <= is_addsub & adder_carry;  // zero for every other op
    end
  end

endmodule : alu

//--- alu_pkg.sv
// alu package: data and register widths, alu select codes and rv32i opcode fields
package alu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int DATA_WIDTH     = 32;  // one word
  localparam int REG_ADDR_WIDTH = 5;   // x0 .. x31
  localparam int ALU_OP_WIDTH   = 4;   // {funct7[5], funct3}
  localparam int SHAMT_WIDTH    = 5;   // shift amount

  ////////////////////////////////////////////////////////////
  // alu select codes
  ////////////////////////////////////////////////////////////
  // bit 3 picks subtract and arithmetic shift, low bits are funct3
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_ADD  = 4'b0000;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SUB  = 4'b1000;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SLL  = 4'b0001;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SLT  = 4'b0010;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SLTU = 4'b0011;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_XOR  = 4'b0100;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SRL  = 4'b0101;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_SRA  = 4'b1101;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_OR   = 4'b0110;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_AND  = 4'b0111;

  ////////////////////////////////////////////////////////////
  // rv32i instruction fields
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate

  localparam logic [6:0] FUNCT7_BASE = 7'h00;  // normal form
  localparam logic [6:0] FUNCT7_ALT  = 7'h20;  // sub / sra / srai

  localparam logic [2:0] FUNCT3_SLL = 3'b001;  // slli needs funct7 check
  localparam logic [2:0] FUNCT3_SR  = 3'b101;  // srli / srai

endpackage : alu_pkg

//--- apb_map_pkg.sv
// apb map package: register addresses, status bit layout and bus widths
package apb_map_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////
  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_INSTR    = 12'h000;  // issue / last instr
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_STATUS   = 12'h004;  // read only
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_REG_BASE = 12'h080;  // x0 at base, x31 at 0x0fc

  ////////////////////////////////////////////////////////////
  // status register
  ////////////////////////////////////////////////////////////
  localparam int STAT_WIDTH       = 2;
  localparam int STAT_CARRY_BIT   = 0;  // carry out of last add / sub
  localparam int STAT_ILLEGAL_BIT = 1;  // last instr was illegal

endpackage : apb_map_pkg

//--- barrel_shifter.sv
// logarithmic barrel shifter for sll, srl and sra
`timescale 1ns/1ps

module barrel_shifter import alu_pkg::*; (
  input  logic [DATA_WIDTH-1:0]  data_i,
  input  logic [SHAMT_WIDTH-1:0] shamt_i,
  input  logic                   right_i,  // 0 = left shift
  input  logic                   arith_i,  // sign fill on right shift
  output logic [DATA_WIDTH-1:0]  data_o
);

  logic [DATA_WIDTH-1:0] data_rev;                   // input in bit-reversed order
  logic [DATA_WIDTH-1:0] stage [0:SHAMT_WIDTH];      // stage outputs
  logic [DATA_WIDTH-1:0] res_rev;                    // last stage, reversed back
  logic                  fill;

  // left shift is a right shift on reversed bits
  assign fill = right_i & arith_i & data_i[DATA_WIDTH-1];

  genvar i, k;
  generate
    for (i = 0; i < DATA_WIDTH; i++) begin : g_rev
      assign data_rev[i] = data_i[DATA_WIDTH-1-i];
      assign res_rev[i]  = stage[SHAMT_WIDTH][DATA_WIDTH-1-i];
    end
  endgenerate

  assign stage[0] = right_i ? data_i : data_rev;

  ////////////////////////////////////////////////////////////
  // shift stages of 1, 2, 4, 8 and 16
  ////////////////////////////////////////////////////////////
  generate
    for (k = 0; k < SHAMT_WIDTH; k++) begin : g_stage
      localparam int STEP = 1 << k;
      assign stage[k+1] = shamt_i[k] ?
                          {{STEP{fill}}, stage[k][DATA_WIDTH-1:STEP]} :
                          stage[k];
    end
  endgenerate

  assign data_o = right_i ? stage[SHAMT_WIDTH] : res_rev;  // undo reversal for left

endmodule : barrel_shifter

//--- exec_ctrl.sv
// apb slave, instruction sequencer and status register of the execute unit
`timescale 1ns/1ps

module exec_ctrl import alu_pkg::*, apb_map_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  // apb slave
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // decoder and alu
  output logic [DATA_WIDTH-1:0]     instr_o,
  input  logic                      legal_i,
  output logic                      alu_wb_o,
  input  logic [DATA_WIDTH-1:0]     alu_res_i,
  input  logic                      alu_carry_i,
  input  logic [REG_ADDR_WIDTH-1:0] alu_dest_i,
  input  logic                      alu_wb_i,
  // register file write port and host read port
  output logic                      rf_we_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_waddr_o,
  output logic [DATA_WIDTH-1:0]     rf_wdata_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_raddr_o,
  input  logic [DATA_WIDTH-1:0]     rf_rdata_i
);

  typedef enum logic [1:0] {IDLE, EXEC, WB} state_t;

  state_t                state_q;
  logic [DATA_WIDTH-1:0] instr_q;
  logic [STAT_WIDTH-1:0] status_q;
  logic                  sel_instr, sel_status, sel_reg;
  logic                  access;     // access phase of any transfer
  logic                  instr_wr;   // access phase of an instr write
  logic                  host_rf_wr;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////
  assign sel_instr  = (paddr_i == ADDR_INSTR);
  assign sel_status = (paddr_i == ADDR_STATUS);
  // window 0x080..0x0fc, word aligned
  assign sel_reg    = (paddr_i[APB_ADDR_WIDTH-1:7] == ADDR_REG_BASE[APB_ADDR_WIDTH-1:7]) &&
                      (paddr_i[1:0] == 2'b00);
  assign rf_raddr_o = paddr_i[REG_ADDR_WIDTH+1:2];

  assign access     = psel_i & penable_i;
  assign instr_wr   = access & pwrite_i & sel_instr;
  assign host_rf_wr = access & pwrite_i & sel_reg;

  // instr write held until the writeback cycle, all else zero wait
  assign pready_o  = psel_i & (!(pwrite_i && sel_instr) || (state_q == WB));
  assign pslverr_o = access & pready_o & pwrite_i &
                     (sel_status | (sel_instr & !alu_wb_i));  // alu wb low = illegal

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (sel_instr)       prdata_o = instr_q;
    else if (sel_status) prdata_o = {{(APB_DATA_WIDTH-STAT_WIDTH){1'b0}}, status_q};
    else if (sel_reg)    prdata_o = rf_rdata_i;
    else                 prdata_o = '0;     // unmapped reads as zero
  end

  ////////////////////////////////////////////////////////////
  // sequencer and status
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q  <= IDLE;
      instr_q  <= '0;
      status_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (instr_wr) begin
          instr_q <= pwdata_i;              // first access cycle
          state_q <= EXEC;
        end
        EXEC: state_q <= WB;                // alu captures at this edge
        WB: begin
          status_q[STAT_ILLEGAL_BIT] <= !alu_wb_i;
          if (alu_wb_i) status_q[STAT_CARRY_BIT] <= alu_carry_i;  // legal only
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign instr_o  = instr_q;
  assign alu_wb_o = (state_q == EXEC) & legal_i;

  // write port owner, alu in wb, host otherwise
  assign rf_we_o    = (state_q == WB) ? alu_wb_i   : host_rf_wr;
  assign rf_waddr_o = (state_q == WB) ? alu_dest_i : rf_raddr_o;
  assign rf_wdata_o = (state_q == WB) ? alu_res_i  : pwdata_i;

endmodule : exec_ctrl

//--- exec_unit_top.sv
// rv32i execute unit top, apb control with decoder, register file and alu
`timescale 1ns/1ps

module exec_unit_top import alu_pkg::*, apb_map_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o
);

  logic [DATA_WIDTH-1:0]     instr;
  logic [REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [DATA_WIDTH-1:0]     rs1_data, rs2_data;
  logic [ALU_OP_WIDTH-1:0]   alu_sel;
  logic [DATA_WIDTH-1:0]     op_a, op_b;
  logic                      legal, alu_wb;
  logic [DATA_WIDTH-1:0]     alu_res;
  logic                      alu_carry, alu_wb_q;
  logic [REG_ADDR_WIDTH-1:0] alu_dest;
  logic                      rf_we;
  logic [REG_ADDR_WIDTH-1:0] rf_waddr, rf_raddr;
  logic [DATA_WIDTH-1:0]     rf_wdata, rf_rdata;

  exec_ctrl u_ctrl (
    .clk_i, .rstn_i,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .instr_o     (instr),
    .legal_i     (legal),
    .alu_wb_o    (alu_wb),
    .alu_res_i   (alu_res),
    .alu_carry_i (alu_carry),
    .alu_dest_i  (alu_dest),
    .alu_wb_i    (alu_wb_q),
    .rf_we_o     (rf_we),
    .rf_waddr_o  (rf_waddr),
    .rf_wdata_o  (rf_wdata),
    .rf_raddr_o  (rf_raddr),
    .rf_rdata_i  (rf_rdata)
  );

  instr_decoder u_dec (
    .instr_i (instr),  .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .sel_o (alu_sel), .op_a_o (op_a), .op_b_o (op_b),
    .rd_addr_o (rd_addr), .legal_o (legal)
  );

  reg_file u_rf (
    .clk_i, .rstn_i,
    .raddr1_i (rs1_addr), .raddr2_i (rs2_addr), .raddr3_i (rf_raddr),
    .rdata1_o (rs1_data), .rdata2_o (rs2_data), .rdata3_o (rf_rdata),
    .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata)
  );

  alu u_alu (
    .clk_i, .rstn_i,
    .sel_i (alu_sel), .op_a_i (op_a), .op_b_i (op_b),
    .res_ro (alu_res), .carry_ro (alu_carry),
    .dest_addr_i (rd_addr), .dest_addr_ro (alu_dest),
    .wb_i (alu_wb), .wb_ro (alu_wb_q)
  );

endmodule : exec_unit_top

//--- instr_decoder.sv
// decoder for rv32i op and op-imm into alu select, operands and destination
`timescale 1ns/1ps

module instr_decoder import alu_pkg::*; (
  input  logic [DATA_WIDTH-1:0]     instr_i,
  output logic [REG_ADDR_WIDTH-1:0] rs1_addr_o,
  output logic [REG_ADDR_WIDTH-1:0] rs2_addr_o,
  input  logic [DATA_WIDTH-1:0]     rs1_data_i,
  input  logic [DATA_WIDTH-1:0]     rs2_data_i,
  output logic [ALU_OP_WIDTH-1:0]   sel_o,
  output logic [DATA_WIDTH-1:0]     op_a_o,
  output logic [DATA_WIDTH-1:0]     op_b_o,
  output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
  output logic                      legal_o
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [DATA_WIDTH-1:0] imm_i;   // sign-extended i-type immediate

  // fixed rv32i field positions
  assign opcode     = instr_i[6:0];
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rd_addr_o  = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign imm_i      = {{(DATA_WIDTH-12){instr_i[31]}}, instr_i[31:20]};

  assign op_a_o = rs1_data_i;

  ////////////////////////////////////////////////////////////
  // select, operand b and legality
  ////////////////////////////////////////////////////////////
  always_comb begin
    sel_o   = ALU_OP_ADD;
    op_b_o  = rs2_data_i;
    legal_o = 1'b0;
    case (opcode)
      OPC_OP: begin
        sel_o   = {funct7[5], funct3};
        // alt funct7 only for sub and sra
        legal_o = (funct7 == FUNCT7_BASE) ||
                  ((funct7 == FUNCT7_ALT) &&
                   ((sel_o == ALU_OP_SUB) || (sel_o == ALU_OP_SRA)));
      end
      OPC_OP_IMM: begin
        op_b_o = imm_i;                        // shamt sits in low 5 bits
        case (funct3)
          FUNCT3_SR: begin                     // srli / srai
            sel_o   = {funct7[5], funct3};
            legal_o = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
          end
          FUNCT3_SLL: begin                    // slli
            sel_o   = {1'b0, funct3};
            legal_o = (funct7 == FUNCT7_BASE);
          end
          default: begin                       // no subi, bit 3 stays low
            sel_o   = {1'b0, funct3};
            legal_o = 1'b1;
          end
        endcase
      end
      default: ;                               // any other opcode illegal
    endcase
  end

endmodule : instr_decoder

//--- reg_file.sv
// 32 x 32-bit register file, x0 hardwired to zero, three reads and one write
`timescale 1ns/1ps

module reg_file import alu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [REG_ADDR_WIDTH-1:0] raddr1_i,  // rs1
  input  logic [REG_ADDR_WIDTH-1:0] raddr2_i,  // rs2
  input  logic [REG_ADDR_WIDTH-1:0] raddr3_i,  // host window
  output logic [DATA_WIDTH-1:0]     rdata1_o,
  output logic [DATA_WIDTH-1:0]     rdata2_o,
  output logic [DATA_WIDTH-1:0]     rdata3_o,
  input  logic                      we_i,
  input  logic [REG_ADDR_WIDTH-1:0] waddr_i,
  input  logic [DATA_WIDTH-1:0]     wdata_i
);

  localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [1:NUM_REGS-1];  // no storage for x0

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin  // x0 writes dropped
      mem[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // read ports, combinational
  ////////////////////////////////////////////////////////////
  assign rdata1_o = (raddr1_i == '0) ? '0 : mem[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : mem[raddr2_i];
  assign rdata3_o = (raddr3_i == '0) ? '0 : mem[raddr3_i];

endmodule : reg_file

//--- src.f
alu_pkg.sv
apb_map_pkg.sv
adder_sub.sv
barrel_shifter.sv
alu.sv
reg_file.sv
instr_decoder.sv
exec_ctrl.sv
exec_unit_top.sv
tb_exec_unit.sv

//--- tb_exec_unit.sv
// testbench for the rv32i execute unit with apb driver, reference model and report
`timescale 1ns/1ps

module tb_exec_unit import alu_pkg::*, apb_map_pkg::*;;

  localparam int RESET_CYCLES    = 4;
  // tests take about 2000 cycles with up to five transfers per instr
  localparam int WATCHDOG_CYCLES = 20000;

  logic        clk, rstn;
  logic [11:0] paddr;
  logic        psel, penable, pwrite;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  logic [31:0] rf_model [0:31];  // expected register contents
  logic [1:0]  stat_model;       // expected status
  integer      seed = 32'h7e0a;
  int          error_count, test_err_start, tests_run, tests_failed;

  exec_unit_top dut (
    .clk_i (clk), .rstn_i (rstn),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run was still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count++;
  endtask

  ////////////////////////////////////////////////////////////
  // bus protocol checks
  ////////////////////////////////////////////////////////////
  // window and status need no wait state
  assert property (@(posedge clk) disable iff (!rstn)
    psel && penable && !(pwrite && paddr == ADDR_INSTR) |-> pready)
    else report_failure("window or status access did not complete in its first cycle");
  // instr write runs three access cycles
  assert property (@(posedge clk) disable iff (!rstn)
    $rose(penable) && psel && pwrite && paddr == ADDR_INSTR |->
    !pready ##1 !pready ##1 pready)
    else report_failure("instruction write did not take exactly two wait states");
  assert property (@(posedge clk) disable iff (!rstn)
    pslverr |-> psel && penable && pready && pwrite)
    else report_failure("pslverr was raised outside a completing write");
  assert property (@(posedge clk) disable iff (!rstn)
    psel && penable && pwrite && paddr == ADDR_STATUS |-> pslverr)
    else report_failure("write to the status register completed without pslverr");

  ////////////////////////////////////////////////////////////
  // reference model and instruction encoding
  ////////////////////////////////////////////////////////////
  function automatic void model_exec(input logic [31:0] instr, input logic [31:0] a,
                                     input logic [31:0] b_reg, output logic [31:0] res,
                                     output logic carry, output logic legal);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] b;
    logic [32:0] sum;
    logic        alt;
    f3    = instr[14:12];
    f7    = instr[31:25];
    b     = b_reg;
    alt   = f7[5];
    res   = '0;
    carry = 1'b0;
    if (instr[6:0] == OPC_OP) begin
      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
    end else if (instr[6:0] == OPC_OP_IMM) begin
      b     = {{20{instr[31]}}, instr[31:20]};  // sign-extended imm
      alt   = (f3 == 3'b101) && f7[5];          // srai only as there is no subi
      legal = (f3 == 3'b001) ? (f7 == 7'h00) :
              (f3 == 3'b101) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
    end else begin
      legal = 1'b0;
    end
    if (legal) begin
      case (f3)
        3'b000: begin
          sum   = alt ? {1'b0, a} + {1'b0, ~b} + 33'd1 : {1'b0, a} + {1'b0, b};
          res   = sum[31:0];
          carry = sum[32];                      // 1 on sub means no borrow
        end
        3'b001: res = a << b[4:0];
        3'b010: res = {31'b0, $signed(a) < $signed(b)};
        3'b011: res = {31'b0, a < b};
        3'b100: res = a ^ b;
        3'b101: begin
          if (alt) res = $signed(a) >>> b[4:0];
          else res = a >> b[4:0];
        end
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [4:0] rand_reg();  // x1 .. x31
    logic [31:0] r;
    r = $random(seed);
    while (r[4:0] == 5'd0)
      r = $random(seed);
    return r[4:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // apb driver and checkers
  ////////////////////////////////////////////////////////////
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
    @(posedge clk);
    #1;
    psel    = 1'b1;   // setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waits   = 0;
    @(negedge clk);   // mid cycle where outputs are settled
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);   // transfer completes here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [4:0] idx, input logic [31:0] val);
    logic [31:0] unused;
    logic        err;
    int          waits;
    apb_access(1'b1, ADDR_REG_BASE + {5'd0, idx, 2'b00}, val, unused, err, waits);
    assert (!err && waits == 0)
      else report_failure($sformatf("write to x%0d failed, pslverr %0b", idx, err));
    if (idx != 5'd0) rf_model[idx] = val;  // x0 stays zero
  endtask

  task automatic reg_check(input logic [4:0] idx);
    logic [31:0] data;
    logic        err;
    int          waits;
    apb_access(1'b0, ADDR_REG_BASE + {5'd0, idx, 2'b00}, '0, data, err, waits);
    assert (!err && waits == 0)
      else report_failure($sformatf("read of x%0d failed, pslverr %0b", idx, err));
    assert (data == rf_model[idx])
      else report_mismatch($sformatf("x%0d reads %h, expected %h", idx, data, rf_model[idx]));
  endtask

  task automatic all_regs_check();
    for (int i = 0; i < 32; i++)
      reg_check(5'(i));
  endtask

  task automatic status_check(input logic [1:0] exp);
    logic [31:0] data;
    logic        err;
    int          waits;
    apb_access(1'b0, ADDR_STATUS, '0, data, err, waits);
    assert (data == {30'b0, exp})
      else report_mismatch($sformatf("status reads %h, expected %h", data, exp));
  endtask

  // runs one instr through the model and the dut and then checks status and rd
  task automatic issue_instr(input logic [31:0] instr);
    logic [31:0] exp_res, unused;
    logic        exp_carry, exp_legal, err;
    int          waits;
    model_exec(instr, rf_model[instr[19:15]], rf_model[instr[24:20]],
               exp_res, exp_carry, exp_legal);
    apb_access(1'b1, ADDR_INSTR, instr, unused, err, waits);
    assert (waits == 2)
      else report_mismatch($sformatf("instr %h took %0d wait states, expected 2", instr, waits));
    assert (err == !exp_legal)
      else report_mismatch($sformatf("instr %h pslverr %0b, expected %0b", instr, err, !exp_legal));
    if (exp_legal) begin
      if (instr[11:7] != 5'd0) rf_model[instr[11:7]] = exp_res;
      stat_model[STAT_ILLEGAL_BIT] = 1'b0;
      stat_model[STAT_CARRY_BIT]   = exp_carry;
    end else begin
      stat_model[STAT_ILLEGAL_BIT] = 1'b1;  // carry holds
    end
    status_check(stat_model);
    reg_check(instr[11:7]);
  endtask

  // entered just after a rising edge, reset spans RESET_CYCLES edges
  task automatic apply_reset();
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
    for (int i = 0; i < 32; i++)
      rf_model[i] = '0;
    stat_model = '0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == test_err_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, error_count - test_err_start);
    end
    test_err_start = error_count;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] d;
    logic        err;
    int          waits;
    rstn    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    apply_reset();

    // register window with random fill then readback
    for (int i = 1; i < 32; i++)
      reg_write(5'(i), $random(seed));
    all_regs_check();
    reg_write(5'd0, $random(seed));
    reg_check(5'd0);
    finish_test("register_window");

    // all ten r-type ops with sub and sra as the alt form
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 1 && f3 != 0 && f3 != 5) continue;
        repeat (3) begin
          rs1 = rand_reg();
          rs2 = rand_reg();
          rd  = rand_reg();
          reg_write(rs1, $random(seed));
          reg_write(rs2, $random(seed));
          issue_instr(r_type(alt ? 7'h20 : 7'h00, rs2, rs1, 3'(f3), rd));
        end
      end
    end
    finish_test("r_type");

    // i-type with negative immediates
    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 == 1 || f3 == 5) continue;   // shifts below
      repeat (2) begin
        rs1 = rand_reg();
        reg_write(rs1, $random(seed));
        d = $random(seed);
        issue_instr(i_type({1'b1, d[10:0]}, rs1, 3'(f3), rand_reg()));
      end
    end
    d = $random(seed);
    reg_write(5'd9, d | 32'h8000_0000);  // negative source
    for (int s = 0; s < 32; s += 31) begin
      issue_instr(i_type({7'h00, 5'(s)}, 5'd9, 3'b001, 5'd10));  // slli
      issue_instr(i_type({7'h00, 5'(s)}, 5'd9, 3'b101, 5'd11));  // srli
      issue_instr(i_type({7'h20, 5'(s)}, 5'd9, 3'b101, 5'd12));  // srai
    end
    issue_instr(i_type({7'h20, d[4:0]}, 5'd9, 3'b101, 5'd13));
    issue_instr(i_type(12'hfff, 5'd9, 3'b000, 5'd0));            // rd = x0
    finish_test("i_type");

    // carry status
    reg_write(5'd1, 32'hffff_ffff);
    reg_write(5'd2, 32'h0000_0001);
    reg_write(5'd3, 32'h0000_0000);
    issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));  // ffffffff + 1
    status_check(2'b01);
    issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));  // xor clears it
    status_check(2'b00);
    issue_instr(i_type(12'h001, 5'd1, 3'b000, 5'd6));      // addi wraps too
    status_check(2'b01);
    issue_instr(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd7));  // 0 - 1 borrows
    status_check(2'b00);
    repeat (4) begin
      rs1 = rand_reg();
      rs2 = rand_reg();
      d   = $random(seed);
      reg_write(rs1, $random(seed));
      reg_write(rs2, $random(seed));
      issue_instr(r_type(d[0] ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rand_reg()));
    end
    finish_test("carry_status");

    // illegal instrs each followed by a legal add
    issue_instr({7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011});  // beq
    all_regs_check();
    issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd14));
    issue_instr(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd8));        // funct7 0x01
    all_regs_check();
    issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd14));
    issue_instr(i_type({7'h20, 5'd3}, 5'd1, 3'b001, 5'd8));      // slli with alt funct7
    all_regs_check();
    issue_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd14));
    finish_test("illegal_instr");

    // reset values and status write error
    apply_reset();
    status_check(2'b00);
    all_regs_check();
    apb_access(1'b0, ADDR_INSTR, '0, d, err, waits);
    assert (d == 32'h0)
      else report_mismatch($sformatf("instr register reads %h after reset", d));
    issue_instr({7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011});  // sets illegal bit
    apb_access(1'b0, ADDR_INSTR, '0, d, err, waits);
    assert (d == {7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011})
      else report_mismatch($sformatf("instr register reads %h, expected last instr", d));
    apb_access(1'b1, ADDR_STATUS, 32'h0, d, err, waits);
    assert (err)
      else report_failure("write to the status register was accepted without an error");
    status_check(2'b10);
    finish_test("reset_errors");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_exec_unit
